// ==== hw/power_ctrl_pkg.sv ====
// shared types for RAM bank power control, at most 16 banks
// all bank pad controls are active low; 0 means the function is engaged
`default_nettype none

package power_ctrl_pkg;

  localparam int MAX_BANKS = 16;

  // level driven onto an active-low pad control
  localparam logic PWR_ASSERT_N  = 1'b0;
  localparam logic PWR_RELEASE_N = 1'b1;

  typedef logic [3:0] bank_idx_t;

  typedef enum logic [1:0] {
    OP_POWER_OFF = 2'd0,
    OP_POWER_ON  = 2'd1,
    OP_RET_ON    = 2'd2,
    OP_RET_OFF   = 2'd3
  } pwr_op_e;

  typedef enum logic {
    ST_DONE     = 1'b0,
    ST_REJECTED = 1'b1
  } pwr_status_e;

  // resting states are S_ON, S_OFF and S_RET
  typedef enum logic [3:0] {
    S_ON,
    S_OFF_CLK,
    S_OFF_ISO,
    S_OFF_RST,
    S_OFF_SW,
    S_OFF_WAIT,
    S_OFF,
    S_ON_SW,
    S_ON_WAIT,
    S_ON_ISO,
    S_ON_RST,
    S_ON_CLK,
    S_RET_CLK,
    S_RET,
    S_UNRET
  } pwr_state_e;

endpackage

`default_nettype wire

// ==== hw/pwr_cmd_decoder.sv ====
// one cycle of latency from cmd_valid_i to the per-bank strobe
// commands to a bank at or above NUM_BANKS vanish without a report
`default_nettype none

module pwr_cmd_decoder
  import power_ctrl_pkg::*;
#(
  parameter int NUM_BANKS = 4
) (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 cmd_valid_i,
  input  bank_idx_t            cmd_bank_i,
  input  pwr_op_e              cmd_op_i,
  output logic [NUM_BANKS-1:0] bank_cmd_valid_o,
  output pwr_op_e              bank_cmd_op_o
);

  logic [NUM_BANKS-1:0] onehot;

  // out-of-range bank numbers match no bit
  always_comb begin
    onehot = '0;
    for (int b = 0; b < NUM_BANKS; b++) begin
      if (cmd_valid_i && (int'(cmd_bank_i) == b)) begin
        onehot[b] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      bank_cmd_valid_o <= '0;
    end else begin
      bank_cmd_valid_o <= onehot;
    end
  end

  // op is shared by all banks, only read alongside the strobe
  always_ff @(posedge clk_i) begin
    if (|onehot) begin
      bank_cmd_op_o <= cmd_op_i;
    end
  end

endmodule

`default_nettype wire

// ==== hw/bank_pwr_sequencer.sv ====
// one bank: steps clock gate, isolation, reset and switch one cycle apart
// a new command must wait for done_o of the previous one
`default_nettype none

module bank_pwr_sequencer
  import power_ctrl_pkg::*;
(
  input  logic        clk_i,
  input  logic        arst_n_i,
  input  logic        cmd_valid_i,
  input  pwr_op_e     cmd_op_i,
  input  logic        switch_ack_ni,
  output logic        switch_no,
  output logic        iso_no,
  output logic        rst_no,
  output logic        set_retentive_no,
  output logic        clkgate_en_no,
  output logic        done_o,
  output pwr_status_e status_o
);

  pwr_state_e state_q;
  logic       cmd_legal;

  // only resting states accept anything
  always_comb begin
    case (cmd_op_i)
      OP_POWER_OFF: cmd_legal = (state_q == S_ON);
      OP_RET_ON:    cmd_legal = (state_q == S_ON);
      OP_POWER_ON:  cmd_legal = (state_q == S_OFF);
      OP_RET_OFF:   cmd_legal = (state_q == S_RET);
      default:      cmd_legal = 1'b0;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q          <= S_ON;
      switch_no        <= PWR_RELEASE_N;
      iso_no           <= PWR_RELEASE_N;
      rst_no           <= PWR_RELEASE_N;
      set_retentive_no <= PWR_RELEASE_N;
      clkgate_en_no    <= PWR_RELEASE_N;
      done_o           <= 1'b0;
      status_o         <= ST_DONE;
    end else begin
      done_o <= 1'b0;

      case (state_q)
        // power off and retention on both start by stopping the clock
        S_ON: begin
          if (cmd_valid_i && cmd_legal) begin
            clkgate_en_no <= PWR_ASSERT_N;
            state_q       <= (cmd_op_i == OP_RET_ON) ? S_RET_CLK : S_OFF_CLK;
          end
        end
        S_OFF_CLK: begin
          iso_no  <= PWR_ASSERT_N;
          state_q <= S_OFF_ISO;
        end
        S_OFF_ISO: begin
          rst_no  <= PWR_ASSERT_N;
          state_q <= S_OFF_RST;
        end
        S_OFF_RST: begin
          switch_no <= PWR_ASSERT_N;
          state_q   <= S_OFF_SW;
        end
        S_OFF_SW, S_OFF_WAIT: begin
          if (!switch_ack_ni) begin
            done_o   <= 1'b1;
            status_o <= ST_DONE;
            state_q  <= S_OFF;
          end else begin
            state_q <= S_OFF_WAIT;
          end
        end
        S_OFF: begin
          if (cmd_valid_i && cmd_legal) begin
            switch_no <= PWR_RELEASE_N;
            state_q   <= S_ON_SW;
          end
        end
        // supply must be back before isolation drops
        S_ON_SW, S_ON_WAIT: begin
          if (switch_ack_ni) begin
            iso_no  <= PWR_RELEASE_N;
            state_q <= S_ON_ISO;
          end else begin
            state_q <= S_ON_WAIT;
          end
        end
        S_ON_ISO: begin
          rst_no  <= PWR_RELEASE_N;
          state_q <= S_ON_RST;
        end
        S_ON_RST: begin
          clkgate_en_no <= PWR_RELEASE_N;
          state_q       <= S_ON_CLK;
        end
        S_ON_CLK: begin
          done_o   <= 1'b1;
          status_o <= ST_DONE;
          state_q  <= S_ON;
        end
        S_RET_CLK: begin
          set_retentive_no <= PWR_ASSERT_N;
          done_o           <= 1'b1;
          status_o         <= ST_DONE;
          state_q          <= S_RET;
        end
        S_RET: begin
          if (cmd_valid_i && cmd_legal) begin
            set_retentive_no <= PWR_RELEASE_N;
            state_q          <= S_UNRET;
          end
        end
        S_UNRET: begin
          clkgate_en_no <= PWR_RELEASE_N;
          done_o        <= 1'b1;
          status_o      <= ST_DONE;
          state_q       <= S_ON;
        end
        // unused encoding, walk the bank down to a known off state
        default: begin
          clkgate_en_no <= PWR_ASSERT_N;
          state_q       <= S_OFF_CLK;
        end
      endcase

      // rejected commands leave state and pads alone
      if (cmd_valid_i && !cmd_legal) begin
        done_o   <= 1'b1;
        status_o <= ST_REJECTED;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/pwr_done_collector.sv ====
// reports one completion per cycle, lowest bank first
// a bank must not complete again while its last report is still pending
`default_nettype none

module pwr_done_collector
  import power_ctrl_pkg::*;
#(
  parameter int NUM_BANKS = 4
) (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic [NUM_BANKS-1:0] seq_done_i,
  input  pwr_status_e          seq_status_i [NUM_BANKS-1:0],
  output logic                 done_o,
  output bank_idx_t            done_bank_o,
  output pwr_status_e          done_status_o
);

  logic [NUM_BANKS-1:0] pending_q;
  logic [NUM_BANKS-1:0] grant;
  pwr_status_e          status_q [NUM_BANKS-1:0];

  // isolate the lowest pending bit
  assign grant  = pending_q & (~pending_q + 1'b1);
  assign done_o = |pending_q;

  always_comb begin
    done_bank_o   = '0;
    done_status_o = ST_DONE;
    for (int b = NUM_BANKS - 1; b >= 0; b--) begin
      if (pending_q[b]) begin
        done_bank_o   = bank_idx_t'(b);
        done_status_o = status_q[b];
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pending_q <= '0;
    end else begin
      pending_q <= (pending_q & ~grant) | seq_done_i;
    end
  end

  always_ff @(posedge clk_i) begin
    for (int b = 0; b < NUM_BANKS; b++) begin
      if (seq_done_i[b]) begin
        status_q[b] <= seq_status_i[b];
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/mem_power_manager.sv ====
// RAM bank power manager, NUM_BANKS from 1 to 16
// no back-pressure; one outstanding command per bank
`default_nettype none

module mem_power_manager
  import power_ctrl_pkg::*;
#(
  parameter int NUM_BANKS = 4
) (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 cmd_valid_i,
  input  bank_idx_t            cmd_bank_i,
  input  pwr_op_e              cmd_op_i,
  output logic [NUM_BANKS-1:0] bank_pwrgate_switch_no,
  input  logic [NUM_BANKS-1:0] bank_pwrgate_switch_ack_ni,
  output logic [NUM_BANKS-1:0] bank_iso_no,
  output logic [NUM_BANKS-1:0] bank_rst_no,
  output logic [NUM_BANKS-1:0] bank_set_retentive_no,
  output logic [NUM_BANKS-1:0] bank_clkgate_en_no,
  output logic                 done_o,
  output bank_idx_t            done_bank_o,
  output pwr_status_e          done_status_o
);

  logic [NUM_BANKS-1:0] bank_cmd_valid;
  pwr_op_e              bank_cmd_op;
  logic [NUM_BANKS-1:0] seq_done;
  pwr_status_e          seq_status [NUM_BANKS-1:0];

  if ((NUM_BANKS < 1) || (NUM_BANKS > MAX_BANKS)) begin : g_num_banks_check
    $error("NUM_BANKS must lie between 1 and %0d", MAX_BANKS);
  end

  pwr_cmd_decoder #(
    .NUM_BANKS(NUM_BANKS)
  ) u_decoder (
    .clk_i,
    .arst_n_i,
    .cmd_valid_i,
    .cmd_bank_i,
    .cmd_op_i,
    .bank_cmd_valid_o(bank_cmd_valid),
    .bank_cmd_op_o   (bank_cmd_op)
  );

  for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
    bank_pwr_sequencer u_seq (
      .clk_i,
      .arst_n_i,
      .cmd_valid_i     (bank_cmd_valid[i]),
      .cmd_op_i        (bank_cmd_op),
      .switch_ack_ni   (bank_pwrgate_switch_ack_ni[i]),
      .switch_no       (bank_pwrgate_switch_no[i]),
      .iso_no          (bank_iso_no[i]),
      .rst_no          (bank_rst_no[i]),
      .set_retentive_no(bank_set_retentive_no[i]),
      .clkgate_en_no   (bank_clkgate_en_no[i]),
      .done_o          (seq_done[i]),
      .status_o        (seq_status[i])
    );
  end

  pwr_done_collector #(
    .NUM_BANKS(NUM_BANKS)
  ) u_collector (
    .clk_i,
    .arst_n_i,
    .seq_done_i  (seq_done),
    .seq_status_i(seq_status),
    .done_o,
    .done_bank_o,
    .done_status_o
  );

endmodule

`default_nettype wire

// ==== verification/mem_power_manager_asserts.sv ====
// bound into every bank sequencer, checks pad ordering and the done strobe
`default_nettype none

module mem_power_manager_asserts
  import power_ctrl_pkg::*;
(
  input logic       clk_i,
  input logic       arst_n_i,
  input logic       switch_no,
  input logic       iso_no,
  input logic       rst_no,
  input logic       set_retentive_no,
  input logic       clkgate_en_no,
  input logic       done_o,
  input pwr_state_e state_i
);
  timeunit 1ns;
  timeprecision 100ps;

  a_iso_with_switch: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !switch_no |-> !iso_no) else $error("isolation released while switch active");

  a_rst_with_switch: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !switch_no |-> !rst_no) else $error("reset released while switch active");

  a_clk_with_ret: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !set_retentive_no |-> !clkgate_en_no) else $error("clock running while retentive");

  a_done_strobe: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    done_o |=> !done_o) else $error("done_o held longer than one cycle");

  // resting off state keeps the switch engaged
  a_off_switch: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (state_i == S_OFF) |-> !switch_no) else $error("switch released in S_OFF");

endmodule

bind bank_pwr_sequencer mem_power_manager_asserts u_asserts (
  .clk_i,
  .arst_n_i,
  .switch_no,
  .iso_no,
  .rst_no,
  .set_retentive_no,
  .clkgate_en_no,
  .done_o,
  .state_i(state_q)
);

`default_nettype wire

// ==== verification/tb_mem_power_manager.sv ====
// random and directed commands against a per-bank reference model
// expects NUM_BANKS = 4, so bank 4 is out of range and must stay silent
`default_nettype none

module tb_mem_power_manager
  import power_ctrl_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_BANKS = 4;
  localparam int TIMEOUT   = 200;

  typedef enum logic [1:0] {M_ON, M_OFF, M_RET} model_state_e;

  logic                 clk;
  logic                 arst_n;
  logic                 cmd_valid;
  bank_idx_t            cmd_bank;
  pwr_op_e              cmd_op;
  logic [NUM_BANKS-1:0] sw_n;
  logic [NUM_BANKS-1:0] ack_n;
  logic [NUM_BANKS-1:0] iso_n;
  logic [NUM_BANKS-1:0] bank_rst_n;
  logic [NUM_BANKS-1:0] ret_n;
  logic [NUM_BANKS-1:0] clkgate_n;
  logic                 done;
  bank_idx_t            done_bank;
  pwr_status_e          done_status;

  model_state_e         model [NUM_BANKS];
  pwr_status_e          exp_status [NUM_BANKS];
  logic [NUM_BANKS-1:0] exp_pending;
  int                   ack_cnt [NUM_BANKS];

  mem_power_manager #(
    .NUM_BANKS(NUM_BANKS)
  ) dut (
    .clk_i                     (clk),
    .arst_n_i                  (arst_n),
    .cmd_valid_i               (cmd_valid),
    .cmd_bank_i                (cmd_bank),
    .cmd_op_i                  (cmd_op),
    .bank_pwrgate_switch_no    (sw_n),
    .bank_pwrgate_switch_ack_ni(ack_n),
    .bank_iso_no               (iso_n),
    .bank_rst_no               (bank_rst_n),
    .bank_set_retentive_no     (ret_n),
    .bank_clkgate_en_no        (clkgate_n),
    .done_o                    (done),
    .done_bank_o               (done_bank),
    .done_status_o             (done_status)
  );

  always #10 clk = ~clk;

  // switch model, ack follows the switch after 1 to 5 cycles
  always @(posedge clk) begin
    #2;
    for (int b = 0; b < NUM_BANKS; b++) begin
      if (ack_n[b] == sw_n[b]) begin
        ack_cnt[b] = 0;
      end else if (ack_cnt[b] == 0) begin
        ack_cnt[b] = 1 + int'($urandom % 5);
      end else begin
        ack_cnt[b]--;
        if (ack_cnt[b] == 0) begin
          ack_n[b] = sw_n[b];
        end
      end
    end
  end

  // legal ops move to a new resting state, anything else is rejected
  function automatic pwr_status_e model_step(input model_state_e cur, input pwr_op_e op,
                                             output model_state_e nxt);
    case (op)
      OP_POWER_OFF: nxt = (cur == M_ON) ? M_OFF : cur;
      OP_POWER_ON:  nxt = (cur == M_OFF) ? M_ON : cur;
      OP_RET_ON:    nxt = (cur == M_ON) ? M_RET : cur;
      default:      nxt = (cur == M_RET) ? M_ON : cur;
    endcase
    return (nxt == cur) ? ST_REJECTED : ST_DONE;
  endfunction

  // {switch, iso, reset, retention, clock gate}
  function automatic logic [4:0] pads_for(input model_state_e s);
    case (s)
      M_OFF:   return 5'b00010;
      M_RET:   return 5'b11100;
      default: return 5'b11111;
    endcase
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "stopped at first error");
  endtask

  // drives one strobe, leaves the bus idle at the next edge plus 2 ns
  task automatic issue_cmd(input int bank, input pwr_op_e op);
    model_state_e nxt;
    cmd_valid = 1'b1;
    cmd_bank  = bank_idx_t'(bank);
    cmd_op    = op;
    if (bank < NUM_BANKS) begin
      exp_status[bank]  = model_step(model[bank], op, nxt);
      model[bank]       = nxt;
      exp_pending[bank] = 1'b1;
    end
    @(posedge clk);
    #2;
    cmd_valid = 1'b0;
  endtask

  task automatic wait_report(input int bank);
    int n;
    n = 0;
    while (exp_pending[bank]) begin
      @(posedge clk);
      #2;
      n++;
      assert (n < TIMEOUT)
        else fail_run($sformatf("no report from bank %0d within %0d cycles", bank, TIMEOUT));
    end
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (|exp_pending) begin
      @(posedge clk);
      #2;
      n++;
      assert (n < TIMEOUT)
        else fail_run("outstanding commands never reported");
    end
  endtask

  task automatic check_pads(input int bank);
    logic [4:0] got;
    got = {sw_n[bank], iso_n[bank], bank_rst_n[bank], ret_n[bank], clkgate_n[bank]};
    assert (got == pads_for(model[bank]))
      else fail_run($sformatf("[FAIL] bank %0d pads {sw,iso,rst,ret,clkgate}: got %h expected %h",
                              bank, got, pads_for(model[bank])));
  endtask

  task automatic run_cmd(input int bank, input pwr_op_e op);
    issue_cmd(bank, op);
    wait_report(bank);
    check_pads(bank);
  endtask

  // every report must match an outstanding command
  always @(negedge clk) begin
    if (arst_n && done) begin
      assert ((int'(done_bank) < NUM_BANKS) && exp_pending[done_bank])
        else fail_run($sformatf("unexpected report from bank %0d", done_bank));
      assert (done_status == exp_status[done_bank])
        else fail_run($sformatf("[FAIL] done_status_o bank %0h: got %h expected %h",
                                done_bank, done_status, exp_status[done_bank]));
      exp_pending[done_bank] = 1'b0;
    end
  end

  initial begin
    int bank;
    pwr_op_e op;
    void'($urandom(32'h38e7_032d));
    clk         = 1'b0;
    arst_n      = 1'b0;
    cmd_valid   = 1'b0;
    cmd_bank    = '0;
    cmd_op      = OP_POWER_OFF;
    ack_n       = '1;
    exp_pending = '0;
    for (int b = 0; b < NUM_BANKS; b++) begin
      model[b] = M_ON;
    end
    repeat (5) @(posedge clk);
    #2;
    arst_n = 1'b1;

    for (int b = 0; b < NUM_BANKS; b++) begin
      check_pads(b);
    end
    assert (!done) else fail_run("done_o high right after reset");

    for (int b = 0; b < NUM_BANKS; b++) begin
      run_cmd(b, OP_POWER_OFF);
      run_cmd(b, OP_POWER_ON);
      run_cmd(b, OP_RET_ON);
      run_cmd(b, OP_RET_OFF);
    end

    // illegal ops must bounce without touching the pads
    run_cmd(0, OP_POWER_ON);
    run_cmd(0, OP_RET_OFF);
    run_cmd(0, OP_POWER_OFF);
    run_cmd(0, OP_RET_ON);
    run_cmd(0, OP_POWER_OFF);
    run_cmd(0, OP_POWER_ON);

    // back to back, one per bank
    issue_cmd(0, OP_RET_ON);
    issue_cmd(1, OP_POWER_OFF);
    issue_cmd(2, OP_POWER_ON);
    issue_cmd(3, OP_RET_OFF);
    wait_idle();
    for (int b = 0; b < NUM_BANKS; b++) begin
      check_pads(b);
    end

    issue_cmd(4, OP_POWER_OFF);
    for (int n = 0; n < TIMEOUT; n++) begin
      @(posedge clk);
      #2;
      assert (!done) else fail_run("report seen for an out-of-range bank");
    end

    repeat (200) begin
      bank = int'($urandom % NUM_BANKS);
      op   = pwr_op_e'($urandom % 4);
      wait_report(bank);
      check_pads(bank);
      issue_cmd(bank, op);
    end
    wait_idle();

    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
hw/power_ctrl_pkg.sv
hw/pwr_cmd_decoder.sv
hw/bank_pwr_sequencer.sv
hw/pwr_done_collector.sv
hw/mem_power_manager.sv
verification/mem_power_manager_asserts.sv
verification/tb_mem_power_manager.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run with Verilator, result taken from the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_mem_power_manager -f verilog.f -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failed" sim.log; then
  exit 1
fi
if ! grep -q "Test completed successfully" sim.log; then
  exit 1
fi
